// File: build.f
rtl/mem_geom_pkg.sv
rtl/conduit_pkg.sv
rtl/pin_decode.sv
rtl/mem_array.sv
rtl/read_pipe.sv
rtl/ext_mem_model.sv
testbench/ext_mem_model_asserts.sv
testbench/tb_ext_mem_model.sv

// File: Makefile
# Verilator build and run of the external memory model testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0 --timescale 1ns/100ps
TOP       := tb_ext_mem_model
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := ALL CHECKS PASSED

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, not the exit status of the simulation
run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_ext_mem_model.sv
// testbench for the external memory model
// drives the conduit pins on the rising edge with write active low,
// keeps a shadow copy of the memory and checks the read return at
// every edge with high drive only where a read was predicted
// run it from the Makefile, which greps the log for the result

module tb_ext_mem_model;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int READ_LATENCY = 2;
   localparam int DRAIN_LIMIT  = 20;
   localparam int LANE_W       = mem_geom_pkg::SYMBOL_W;
   localparam int unsigned SEED = 32'h588d_a6dd;
   // every pin wired on the board and only the write strobe asserts low
   localparam conduit_pkg::pin_flags_t WR_LOW =
      conduit_pkg::pin_flags_t'(1 << conduit_pkg::PIN_WR);

   logic                     clk = 1'b0;
   logic                     internal_reset;
   mem_geom_pkg::byte_addr_t address;
   mem_geom_pkg::word_t      write_data;
   mem_geom_pkg::byte_en_t   byte_enable;
   logic                     chip_select;
   logic                     read;
   logic                     write;
   logic                     output_enable;
   mem_geom_pkg::word_t      read_data;
   logic                     read_drive;

   // shadow of the array and the reads still in flight
   mem_geom_pkg::word_t shadow [mem_geom_pkg::NUM_WORDS];
   int                  due_q[$];
   mem_geom_pkg::word_t expect_q[$];
   int                  edge_cnt = 0;
   int                  reads_checked = 0;

   ext_mem_model #(
      .ACTIVE_LOW   (WR_LOW),
      .PIN_USE      (conduit_pkg::ALL_PINS_USED),
      .READ_LATENCY (READ_LATENCY)
   ) dut (
      .clk            (clk),
      .internal_reset (internal_reset),
      .address        (address),
      .write_data     (write_data),
      .byte_enable    (byte_enable),
      .chip_select    (chip_select),
      .read           (read),
      .write          (write),
      .output_enable  (output_enable),
      .read_data      (read_data),
      .read_drive     (read_drive)
   );

   // 20 ns period
   always #10 clk = ~clk;

   // ------------------------------------------------------------
   // reference model and compare tasks
   // ------------------------------------------------------------

   // one bus cycle with the pin intent given as active-high flags
   // a write merges enabled lanes into the shadow and a read returns
   // only the enabled lanes and reports whether it drives the bus
   function automatic mem_geom_pkg::word_t model_cycle(
      input  logic cs, input logic rd, input logic wr, input logic oe,
      input  mem_geom_pkg::byte_addr_t addr, input mem_geom_pkg::byte_en_t be,
      input  mem_geom_pkg::word_t wdata, output logic drive);
      mem_geom_pkg::word_idx_t idx;
      mem_geom_pkg::word_t     result;
      idx    = mem_geom_pkg::word_idx_t'(addr >> mem_geom_pkg::LANE_SHIFT);
      result = '0;
      // write beats read
      drive  = cs & rd & oe & ~wr;
      for (int i = 0; i < mem_geom_pkg::NUM_SYMBOLS; i++) begin
         if (be[i] && drive)
            result[i*LANE_W +: LANE_W] = shadow[idx][i*LANE_W +: LANE_W];
         if (be[i] && cs && wr)
            shadow[idx][i*LANE_W +: LANE_W] = wdata[i*LANE_W +: LANE_W];
      end
      return result;
   endfunction

   task automatic check_word(input string name, input mem_geom_pkg::word_t expected,
                             input mem_geom_pkg::word_t actual);
      if (actual !== expected) begin
         $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
         $display("CHECKS FAILED");
         $fatal(1, "%s mismatch", name);
      end
   endtask

   task automatic check_drive(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("[ERROR] t=%0t %s expected %b actual %b", $time, name, expected, actual);
         $display("CHECKS FAILED");
         $fatal(1, "%s mismatch", name);
      end
   endtask

   // outputs sampled at every edge before the edge updates them
   always @(posedge clk) begin
      edge_cnt <= edge_cnt + 1;
      if (due_q.size() > 0 && due_q[0] == edge_cnt) begin
         check_drive("read_drive", 1'b1, read_drive);
         check_word("read_data", expect_q.pop_front(), read_data);
         void'(due_q.pop_front());
         reads_checked++;
      end else if (due_q.size() > 0 && due_q[0] < edge_cnt) begin
         $display("a read return due at edge %0d was never compared", due_q[0]);
         $display("CHECKS FAILED");
         $fatal(1, "missed read return");
      end else begin
         // idle edge including all of reset
         check_drive("read_drive", 1'b0, read_drive);
         check_word("read_data", '0, read_data);
      end
   end

   // ------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------

   // drive one cycle that the DUT samples at the next edge
   // the return is seen READ_LATENCY edges after that
   task automatic drive_cycle(input logic cs, input logic rd, input logic wr,
                              input logic oe, input mem_geom_pkg::byte_addr_t addr,
                              input mem_geom_pkg::byte_en_t be,
                              input mem_geom_pkg::word_t wdata);
      mem_geom_pkg::word_t expect_word;
      logic                expect_drive;
      @(posedge clk);
      chip_select   <= cs;
      read          <= rd;
      // write pin asserts low on this board
      write         <= ~wr;
      output_enable <= oe;
      address       <= addr;
      byte_enable   <= be;
      write_data    <= wdata;
      expect_word = model_cycle(cs, rd, wr, oe, addr, be, wdata, expect_drive);
      if (expect_drive) begin
         due_q.push_back(edge_cnt + 1 + READ_LATENCY);
         expect_q.push_back(expect_word);
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
   endtask

   // quiet bus until every predicted read has come back
   task automatic wait_drained(input int limit);
      int waited;
      waited = 0;
      while (due_q.size() > 0) begin
         if (waited >= limit) begin
            $display("timeout, %0d reads still pending after %0d cycles",
                     due_q.size(), limit);
            $display("CHECKS FAILED");
            $fatal(1, "read pipeline did not drain");
         end
         idle_cycles(1);
         waited++;
      end
   endtask

   initial begin
      mem_geom_pkg::byte_addr_t addrs [16];
      void'($urandom(SEED));
      internal_reset <= 1'b1;
      address        <= '0;
      write_data     <= '0;
      byte_enable    <= '0;
      chip_select    <= 1'b0;
      read           <= 1'b0;
      write          <= 1'b1;
      output_enable  <= 1'b0;
      for (int i = 0; i < mem_geom_pkg::NUM_WORDS; i++) begin
         shadow[i] = '0;
      end
      repeat (8) @(posedge clk);
      internal_reset <= 1'b0;
      idle_cycles(2);

      // reset leaves every word at zero
      for (int i = 0; i < 8; i++)
         drive_cycle(1'b1, 1'b1, 1'b0, 1'b1, mem_geom_pkg::byte_addr_t'($urandom()), '1, '0);
      wait_drained(DRAIN_LIMIT);

      // full-word writes each read back on its own
      for (int i = 0; i < 16; i++) begin
         addrs[i] = mem_geom_pkg::byte_addr_t'($urandom());
         drive_cycle(1'b1, 1'b0, 1'b1, 1'b0, addrs[i], '1, mem_geom_pkg::word_t'($urandom()));
         idle_cycles(1);
         drive_cycle(1'b1, 1'b1, 1'b0, 1'b1, addrs[i], '1, '0);
         wait_drained(DRAIN_LIMIT);
      end

      // partial writes crowded onto words 0 to 7
      for (int i = 0; i < 16; i++)
         drive_cycle(1'b1, 1'b0, 1'b1, 1'b0, mem_geom_pkg::byte_addr_t'($urandom() % 32),
                     mem_geom_pkg::byte_en_t'($urandom()), mem_geom_pkg::word_t'($urandom()));
      // back to back full reads and then lane-masked reads
      for (int i = 0; i < 8; i++)
         drive_cycle(1'b1, 1'b1, 1'b0, 1'b1, mem_geom_pkg::byte_addr_t'(i * 4), '1, '0);
      for (int i = 0; i < 8; i++)
         drive_cycle(1'b1, 1'b1, 1'b0, 1'b1, mem_geom_pkg::byte_addr_t'(i * 4),
                     mem_geom_pkg::byte_en_t'($urandom()), '0);
      wait_drained(DRAIN_LIMIT);

      // suppressed reads without output enable, without chip select
      // and with write also up
      drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, addrs[0], '1, '0);
      drive_cycle(1'b0, 1'b1, 1'b0, 1'b1, addrs[1], '1, '0);
      drive_cycle(1'b1, 1'b1, 1'b1, 1'b1, addrs[2], '1, mem_geom_pkg::word_t'($urandom()));
      drive_cycle(1'b1, 1'b1, 1'b0, 1'b1, addrs[2], '1, '0);
      wait_drained(DRAIN_LIMIT);

      // selected cycles with the write pin held high must not write
      for (int i = 0; i < 4; i++)
         drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, addrs[i], '1, mem_geom_pkg::word_t'($urandom()));
      for (int i = 0; i < 4; i++)
         drive_cycle(1'b1, 1'b1, 1'b0, 1'b1, addrs[i], '1, '0);
      wait_drained(DRAIN_LIMIT);

      // a second reset must clear words that now hold written data
      @(posedge clk);
      internal_reset <= 1'b1;
      repeat (8) @(posedge clk);
      internal_reset <= 1'b0;
      for (int i = 0; i < mem_geom_pkg::NUM_WORDS; i++) begin
         shadow[i] = '0;
      end
      for (int i = 0; i < 8; i++)
         drive_cycle(1'b1, 1'b1, 1'b0, 1'b1, addrs[i], '1, '0);
      wait_drained(DRAIN_LIMIT);
      idle_cycles(2);

      $display("%0d read returns compared", reads_checked);
      if (reads_checked > 0 && due_q.size() == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: testbench/ext_mem_model_asserts.sv
// concurrent checks on the read return of the memory model
// bound into every ext_mem_model instance, the read decode is
// rebuilt from the top level pins and compared with read_drive

module ext_mem_model_asserts #(
   parameter conduit_pkg::pin_flags_t ACTIVE_LOW   = conduit_pkg::ALL_ACTIVE_HIGH,
   parameter conduit_pkg::pin_flags_t PIN_USE      = conduit_pkg::ALL_PINS_USED,
   parameter int                      READ_LATENCY = 2
) (
   input logic                clk,
   input logic                internal_reset,
   input logic                chip_select,
   input logic                read,
   input logic                write,
   input logic                output_enable,
   input logic                read_drive,
   input mem_geom_pkg::word_t read_data
);
   timeunit 1ns;
   timeprecision 100ps;

   // pins with polarity removed
   logic cs_a;
   logic rd_a;
   logic wr_a;
   logic oe_a;
   // strobes with unwired pins rebuilt
   logic cs_u;
   logic rd_u;
   logic wr_u;
   logic oe_u;
   // a read that should come back on the bus
   logic read_seen;

   assign cs_a = chip_select   ^ ACTIVE_LOW[conduit_pkg::PIN_CS];
   assign rd_a = read          ^ ACTIVE_LOW[conduit_pkg::PIN_RD];
   assign wr_a = write         ^ ACTIVE_LOW[conduit_pkg::PIN_WR];
   assign oe_a = output_enable ^ ACTIVE_LOW[conduit_pkg::PIN_OE];

   assign cs_u = PIN_USE[conduit_pkg::PIN_CS] ? cs_a :
                 ((PIN_USE[conduit_pkg::PIN_RD] & rd_a) | (PIN_USE[conduit_pkg::PIN_WR] & wr_a));
   assign rd_u = PIN_USE[conduit_pkg::PIN_RD] ? rd_a :
                 (cs_u & ~(PIN_USE[conduit_pkg::PIN_WR] & wr_a));
   assign wr_u = PIN_USE[conduit_pkg::PIN_WR] ? wr_a :
                 (cs_u & ~(PIN_USE[conduit_pkg::PIN_RD] & rd_a));
   assign oe_u = PIN_USE[conduit_pkg::PIN_OE] ? oe_a : rd_u;

   assign read_seen = cs_u & rd_u & oe_u & ~wr_u;

   // ------------------------------------------------------------
   // properties
   // ------------------------------------------------------------

   a_quiet_in_reset : assert property (@(posedge clk) internal_reset |-> !read_drive)
      else $error("read_drive high during reset");

   // drive appears READ_LATENCY edges after the read was sampled
   a_drive_timing : assert property (@(posedge clk) disable iff (internal_reset)
      $past(!internal_reset, READ_LATENCY) |-> read_drive == $past(read_seen, READ_LATENCY))
      else $error("read_drive does not follow the decoded read");

   a_zero_when_idle : assert property (@(posedge clk) !read_drive |-> read_data == '0)
      else $error("read_data nonzero while read_drive is low");

endmodule

bind ext_mem_model ext_mem_model_asserts #(
   .ACTIVE_LOW   (ACTIVE_LOW),
   .PIN_USE      (PIN_USE),
   .READ_LATENCY (READ_LATENCY)
) u_asserts (
   .clk            (clk),
   .internal_reset (internal_reset),
   .chip_select    (chip_select),
   .read           (read),
   .write          (write),
   .output_enable  (output_enable),
   .read_drive     (read_drive),
   .read_data      (read_data)
);

// File: rtl/ext_mem_model.sv
// synthesizable single port external memory model, top level
// the conduit pins are decoded into requests, writes land in the
// word array on the clock, and reads come back through a pipeline
// of READ_LATENCY cycles with a drive flag in place of a tristate
// set ACTIVE_LOW and PIN_USE to match the board's pin wiring

module ext_mem_model #(
   // per pin polarity, bit set means the pin asserts low
   parameter conduit_pkg::pin_flags_t ACTIVE_LOW   = conduit_pkg::ALL_ACTIVE_HIGH,
   // per pin usage, bit clear means the pin is not wired
   parameter conduit_pkg::pin_flags_t PIN_USE      = conduit_pkg::ALL_PINS_USED,
   // read latency in clock cycles, 1 to 4
   parameter int                      READ_LATENCY = 2
) (
   input  logic                     clk,
   input  logic                     internal_reset,
   // conduit address, data and lanes
   input  mem_geom_pkg::byte_addr_t address,
   input  mem_geom_pkg::word_t      write_data,
   input  mem_geom_pkg::byte_en_t   byte_enable,
   // conduit control pins, raw polarity
   input  logic                     chip_select,
   input  logic                     read,
   input  logic                     write,
   input  logic                     output_enable,
   // read return, read_drive marks when the bus would be driven
   output mem_geom_pkg::word_t      read_data,
   output logic                     read_drive
);

   // decoded request, shared by the array and the pipeline
   mem_geom_pkg::word_idx_t word_idx;
   mem_geom_pkg::byte_en_t  lanes;
   logic                    wr_req;
   logic                    rd_req;

   // array word before any write at this edge
   mem_geom_pkg::word_t     stored_word;

   // ------------------------------------------------------------
   // pin decode
   // ------------------------------------------------------------

   pin_decode #(
      .ACTIVE_LOW (ACTIVE_LOW),
      .PIN_USE    (PIN_USE)
   ) u_pin_decode (
      .address       (address),
      .byte_enable   (byte_enable),
      .chip_select   (chip_select),
      .read          (read),
      .write         (write),
      .output_enable (output_enable),
      .word_idx      (word_idx),
      .lanes         (lanes),
      .wr_req        (wr_req),
      .rd_req        (rd_req)
   );

   // ------------------------------------------------------------
   // storage and read return
   // ------------------------------------------------------------

   mem_array u_mem_array (
      .clk            (clk),
      .internal_reset (internal_reset),
      .word_idx       (word_idx),
      .lanes          (lanes),
      .wr_req         (wr_req),
      .write_data     (write_data),
      .stored_word    (stored_word)
   );

   read_pipe #(
      .READ_LATENCY (READ_LATENCY)
   ) u_read_pipe (
      .clk            (clk),
      .internal_reset (internal_reset),
      .rd_req         (rd_req),
      .lanes          (lanes),
      .stored_word    (stored_word),
      .read_data      (read_data),
      .read_drive     (read_drive)
   );

endmodule

// File: rtl/read_pipe.sv
// read latency pipeline of the external memory model
// a READ_LATENCY deep shift register of a drive flag and a data word
// stage 0 samples the decoded read and the lane-masked stored word,
// the last stage drives the model outputs for exactly one cycle
// idle stages carry zero, so the outputs are zero when not driving

module read_pipe #(
   // cycles from the read edge to the edge that sees the data, 1 to 4
   parameter int READ_LATENCY = 2
) (
   input  logic                   clk,
   input  logic                   internal_reset,
   input  logic                   rd_req,
   input  mem_geom_pkg::byte_en_t lanes,
   input  mem_geom_pkg::word_t    stored_word,
   output mem_geom_pkg::word_t    read_data,
   output logic                   read_drive
);

   // per stage drive flag, high while that stage holds a read
   logic                drive_q [READ_LATENCY];
   // per stage payload, zero in stages without a read
   mem_geom_pkg::word_t data_q  [READ_LATENCY];

   // stage 0 input
   mem_geom_pkg::word_t masked_word;

   // ------------------------------------------------------------
   // stage 0 input
   // ------------------------------------------------------------

   // disabled lanes read back as zero, same lane rule as writes
   // no read at this edge means a zero word enters the pipe
   assign masked_word = rd_req ? (stored_word & mem_geom_pkg::lane_mask(lanes)) : '0;

   // ------------------------------------------------------------
   // shift register
   // ------------------------------------------------------------

   always_ff @(posedge clk, posedge internal_reset) begin
      if (internal_reset) begin
         for (int i = 0; i < READ_LATENCY; i++) begin
            drive_q[i] <= 1'b0;
            data_q[i]  <= '0;
         end
      end else begin
         drive_q[0] <= rd_req;
         data_q[0]  <= masked_word;
         // one stage per edge, no stall since there is no back-pressure
         for (int i = 1; i < READ_LATENCY; i++) begin
            drive_q[i] <= drive_q[i-1];
            data_q[i]  <= data_q[i-1];
         end
      end
   end

   // ------------------------------------------------------------
   // outputs
   // ------------------------------------------------------------

   // last stage faces the bus
   assign read_drive = drive_q[READ_LATENCY-1];
   assign read_data  = data_q[READ_LATENCY-1];

endmodule

// File: rtl/mem_array.sv
// word storage of the external memory model
// writes merge the enabled byte lanes into the stored word on the
// rising clock edge and the read port is combinational, showing the
// word at the current index before any write of this edge
// internal_reset clears every word asynchronously

module mem_array (
   input  logic                    clk,
   input  logic                    internal_reset,
   input  mem_geom_pkg::word_idx_t word_idx,
   input  mem_geom_pkg::byte_en_t  lanes,
   input  logic                    wr_req,
   input  mem_geom_pkg::word_t     write_data,
   output mem_geom_pkg::word_t     stored_word
);

   // storage with one entry per word index
   mem_geom_pkg::word_t mem [mem_geom_pkg::NUM_WORDS];

   // bit mask of the enabled lanes
   mem_geom_pkg::word_t wr_mask;

   // word after the lane merge
   mem_geom_pkg::word_t merged_word;

   // ------------------------------------------------------------
   // write datapath
   // ------------------------------------------------------------

   assign wr_mask = mem_geom_pkg::lane_mask(lanes);

   // old bits outside the enabled lanes and new bits inside
   assign merged_word = (stored_word & ~wr_mask) | (write_data & wr_mask);

   always_ff @(posedge clk, posedge internal_reset) begin
      if (internal_reset) begin
         // whole array goes to zero
         for (int i = 0; i < mem_geom_pkg::NUM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_req) begin
         mem[word_idx] <= merged_word;
      end
   end

   // ------------------------------------------------------------
   // read port
   // ------------------------------------------------------------

   // a read at edge k sees the word before a write committed at
   // that same edge
   assign stored_word = mem[word_idx];

endmodule

// File: rtl/pin_decode.sv
// conduit pin decoder of the external memory model
// corrects pin polarity, rebuilds strobes that the board does not
// wire, and forms the internal write and read requests together with
// the word index and the byte lanes
// purely combinational, no state

module pin_decode #(
   parameter conduit_pkg::pin_flags_t ACTIVE_LOW = conduit_pkg::ALL_ACTIVE_HIGH,
   parameter conduit_pkg::pin_flags_t PIN_USE    = conduit_pkg::ALL_PINS_USED
) (
   input  mem_geom_pkg::byte_addr_t address,
   input  mem_geom_pkg::byte_en_t   byte_enable,
   input  logic                     chip_select,
   input  logic                     read,
   input  logic                     write,
   input  logic                     output_enable,
   output mem_geom_pkg::word_idx_t  word_idx,
   output mem_geom_pkg::byte_en_t   lanes,
   output logic                     wr_req,
   output logic                     rd_req
);

   // pins after polarity correction, all active high
   logic                   cs_p;
   logic                   rd_p;
   logic                   wr_p;
   logic                   oe_p;
   mem_geom_pkg::byte_en_t be_p;

   // strobes after missing pins were rebuilt
   logic                   cs_s;
   logic                   rd_s;
   logic                   wr_s;
   logic                   oe_s;

   // ------------------------------------------------------------
   // polarity correction
   // ------------------------------------------------------------

   // xor with the flag inverts an active-low pin
   assign cs_p = chip_select   ^ ACTIVE_LOW[conduit_pkg::PIN_CS];
   assign rd_p = read          ^ ACTIVE_LOW[conduit_pkg::PIN_RD];
   assign wr_p = write         ^ ACTIVE_LOW[conduit_pkg::PIN_WR];
   assign oe_p = output_enable ^ ACTIVE_LOW[conduit_pkg::PIN_OE];
   // one flag covers the whole byte enable bus
   assign be_p = byte_enable
               ^ {mem_geom_pkg::NUM_SYMBOLS{ACTIVE_LOW[conduit_pkg::PIN_BE]}};

   // ------------------------------------------------------------
   // synthesis of unwired strobes
   // ------------------------------------------------------------

   // no chip select pin: the part is selected by read or write
   // only wired strobes count, so a floating input cannot select it
   assign cs_s = PIN_USE[conduit_pkg::PIN_CS] ? cs_p :
                 ((PIN_USE[conduit_pkg::PIN_RD] & rd_p) |
                  (PIN_USE[conduit_pkg::PIN_WR] & wr_p));

   // no read pin: a selected cycle without write is a read
   assign rd_s = PIN_USE[conduit_pkg::PIN_RD] ? rd_p :
                 (cs_s & ~(PIN_USE[conduit_pkg::PIN_WR] & wr_p));

   // no write pin: a selected cycle without read is a write
   assign wr_s = PIN_USE[conduit_pkg::PIN_WR] ? wr_p :
                 (cs_s & ~(PIN_USE[conduit_pkg::PIN_RD] & rd_p));

   // no output enable pin: the bus is enabled whenever we read
   assign oe_s = PIN_USE[conduit_pkg::PIN_OE] ? oe_p : rd_s;

   // no byte enable bus: every lane takes part
   assign lanes = PIN_USE[conduit_pkg::PIN_BE] ? be_p : '1;

   // ------------------------------------------------------------
   // requests and word index
   // ------------------------------------------------------------

   assign wr_req = cs_s & wr_s;

   // write wins when both strobes are up, the read is dropped
   // a read without output enable would never reach the bus
   assign rd_req = cs_s & rd_s & oe_s & ~wr_s;

   // lane bits are dropped, the byte enables select within the word
   assign word_idx = address[mem_geom_pkg::ADDR_W-1:mem_geom_pkg::LANE_SHIFT];

endmodule

// File: rtl/conduit_pkg.sv
// description of the external conduit pins of the memory model
// one flag bit per control pin, used both for the polarity option
// and for the pin-usage option of a board configuration
// refer to items by scoped name

package conduit_pkg;

   // ------------------------------------------------------------
   // pin flag vector
   // ------------------------------------------------------------

   // number of control pins that carry an option
   localparam int PIN_COUNT = 5;

   // bit i set means the option applies to pin i
   typedef logic [PIN_COUNT-1:0] pin_flags_t;

   // bit positions inside pin_flags_t
   localparam int PIN_CS = 0;
   // read strobe
   localparam int PIN_RD = 1;
   // write strobe
   localparam int PIN_WR = 2;
   // output enable of the data bus
   localparam int PIN_OE = 3;
   // byte enable bus, one flag for all lanes
   localparam int PIN_BE = 4;

   // ------------------------------------------------------------
   // defaults
   // ------------------------------------------------------------

   // every pin is wired on the board
   localparam pin_flags_t ALL_PINS_USED   = '1;
   // every pin asserts high
   localparam pin_flags_t ALL_ACTIVE_HIGH = '0;

endpackage

// File: rtl/mem_geom_pkg.sv
// word and address geometry of the external memory model
// holds the lane and width constants, the vector typedefs that carry
// a meaning, and the byte-lane mask helper shared by the array, the
// read pipeline and the testbench reference model
// refer to items by scoped name, the package is never imported

package mem_geom_pkg;

   // ------------------------------------------------------------
   // lane geometry
   // ------------------------------------------------------------

   // bits per byte lane
   localparam int SYMBOL_W    = 8;
   // byte lanes per stored word
   localparam int NUM_SYMBOLS = 4;
   // byte address width seen on the pins
   localparam int ADDR_W      = 8;

   // ------------------------------------------------------------
   // derived sizes
   // ------------------------------------------------------------

   // low address bits that select a lane inside a word
   localparam int LANE_SHIFT  = $clog2(NUM_SYMBOLS);
   // word index is the byte address without its lane bits
   localparam int WORD_IDX_W  = ADDR_W - LANE_SHIFT;
   // one word per word index value
   localparam int NUM_WORDS   = 2 ** WORD_IDX_W;
   // full word width
   localparam int DATA_W      = SYMBOL_W * NUM_SYMBOLS;

   // ------------------------------------------------------------
   // vector types
   // ------------------------------------------------------------

   typedef logic [ADDR_W-1:0]      byte_addr_t;
   typedef logic [WORD_IDX_W-1:0]  word_idx_t;
   typedef logic [DATA_W-1:0]      word_t;
   // one enable bit per lane, bit i covers data bits of lane i
   typedef logic [NUM_SYMBOLS-1:0] byte_en_t;

   // widen a byte enable into a bit mask over a whole word
   // each enable bit is copied across the SYMBOL_W bits of its lane
   function automatic word_t lane_mask(input byte_en_t be);
      word_t mask;
      mask = '0;
      for (int i = 0; i < NUM_SYMBOLS; i++) begin
         mask[i*SYMBOL_W +: SYMBOL_W] = {SYMBOL_W{be[i]}};
      end
      return mask;
   endfunction

endpackage
